// ==== source/roce_pkg.sv ====
/*
 * RoCE glue package
 * widths, opcodes and the typed records exchanged between the user,
 * the protocol core and the network side of the stack
 */
package roce_pkg;

  // field widths
  localparam int OPCODE_BITS = 5;
  localparam int QPN_BITS    = 10;
  localparam int VADDR_BITS  = 32;
  localparam int LEN_BITS    = 16;
  localparam int SSN_BITS    = 24;
  localparam int NET_BITS    = 32;
  localparam int COUNT_BITS  = 32;

  // flat word handed to the core send queue
  // opcode, qpn, host, last, vaddr, len
  localparam int SQ_FRAME_BITS = OPCODE_BITS + QPN_BITS + 2 + VADDR_BITS + LEN_BITS;

  // flat ack word from the core
  // rd, qpn, ssn
  localparam int ACK_FRAME_BITS = 1 + QPN_BITS + SSN_BITS;

  // reflected CRC-32 for the outgoing ICRC
  localparam logic [NET_BITS-1:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [NET_BITS-1:0] CRC_INIT = 32'hFFFF_FFFF;

  // RC opcodes understood by the core
  typedef enum logic [OPCODE_BITS-1:0] {
    RC_SEND       = 5'h04,
    RC_RDMA_WRITE = 5'h0A,
    RC_RDMA_READ  = 5'h0C
  } rdma_opcode_e;

  // user request
  typedef struct packed {
    rdma_opcode_e           opcode;
    logic [QPN_BITS-1:0]    qpn;
    // host memory vs card memory
    logic                   host;
    // last request of a message
    logic                   last;
    logic [VADDR_BITS-1:0]  vaddr;
    logic [LEN_BITS-1:0]    len;
  } rdma_req_t;

  // user ack
  typedef struct packed {
    // read completion when set, write otherwise
    logic                   rd;
    logic [QPN_BITS-1:0]    qpn;
    logic [SSN_BITS-1:0]    ssn;
  } rdma_ack_t;

  // one network stream beat, all bytes valid
  typedef struct packed {
    logic [NET_BITS-1:0]    data;
    logic                   last;
  } net_beat_t;

endpackage

// ==== source/rdma_flow.sv ====
/*
 * RDMA flow control
 * frames typed user requests into the core send-queue word, unframes
 * core acks into typed acks and caps the number of requests in flight
 */
module rdma_flow #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                                 nclk,
  input  logic                                 arst_n,

  // user send queue
  input  roce_pkg::rdma_req_t                  sq_req,
  input  logic                                 sq_valid,
  output logic                                 sq_ready,

  // core send queue
  output logic [roce_pkg::SQ_FRAME_BITS-1:0]   stack_sq_frame,
  output logic                                 stack_sq_valid,
  input  logic                                 stack_sq_ready,

  // core acks
  input  logic [roce_pkg::ACK_FRAME_BITS-1:0]  stack_ack_frame,
  input  logic                                 stack_ack_valid,
  output logic                                 stack_ack_ready,

  // user acks
  output roce_pkg::rdma_ack_t                  ack,
  output logic                                 ack_valid,
  input  logic                                 ack_ready
);

  // send-queue field offsets, opcode sits at bit 0
  localparam int SQ_OFFS_QPN   = roce_pkg::OPCODE_BITS;
  localparam int SQ_OFFS_HOST  = SQ_OFFS_QPN + roce_pkg::QPN_BITS;
  localparam int SQ_OFFS_LAST  = SQ_OFFS_HOST + 1;
  localparam int SQ_OFFS_VADDR = SQ_OFFS_LAST + 1;
  localparam int SQ_OFFS_LEN   = SQ_OFFS_VADDR + roce_pkg::VADDR_BITS;

  // ack field offsets, rd sits at bit 0
  localparam int ACK_OFFS_QPN  = 1;
  localparam int ACK_OFFS_SSN  = ACK_OFFS_QPN + roce_pkg::QPN_BITS;

  // wide enough to hold MAX_OUTSTANDING itself
  localparam int CNT_BITS = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_BITS-1:0] outstanding;
  logic                credit;
  logic                sq_fire;
  logic                ack_fire;

  // free slot left
  assign credit = (outstanding < CNT_BITS'(MAX_OUTSTANDING));

  // both directions of the sq handshake are held off without credit
  assign stack_sq_valid = sq_valid & credit;
  assign sq_ready       = stack_sq_ready & credit;

  // ack handshake is passed through untouched
  assign ack_valid       = stack_ack_valid;
  assign stack_ack_ready = ack_ready;

  assign sq_fire  = sq_valid & sq_ready;
  assign ack_fire = stack_ack_valid & ack_ready;

  // request framing
  always_comb begin
    stack_sq_frame[0 +: roce_pkg::OPCODE_BITS]             = sq_req.opcode;
    stack_sq_frame[SQ_OFFS_QPN +: roce_pkg::QPN_BITS]      = sq_req.qpn;
    stack_sq_frame[SQ_OFFS_HOST]                           = sq_req.host;
    stack_sq_frame[SQ_OFFS_LAST]                           = sq_req.last;
    stack_sq_frame[SQ_OFFS_VADDR +: roce_pkg::VADDR_BITS]  = sq_req.vaddr;
    stack_sq_frame[SQ_OFFS_LEN +: roce_pkg::LEN_BITS]      = sq_req.len;
  end

  // ack unframing
  always_comb begin
    ack.rd  = stack_ack_frame[0];
    ack.qpn = stack_ack_frame[ACK_OFFS_QPN +: roce_pkg::QPN_BITS];
    ack.ssn = stack_ack_frame[ACK_OFFS_SSN +: roce_pkg::SSN_BITS];
  end

  // requests in flight
  // request and ack in the same cycle cancel out
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
    end else begin
      case ({sq_fire, ack_fire})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

endmodule

// ==== source/icrc.sv ====
/*
 * Outgoing ICRC stage
 * passes core packets to the network and appends one beat with the
 * CRC-32 over all packet bytes after the last data beat
 */
module icrc (
  input  logic                 nclk,
  input  logic                 arst_n,

  // from the core
  input  roce_pkg::net_beat_t  stack_tx,
  input  logic                 stack_tx_valid,
  output logic                 stack_tx_ready,

  // to the network
  output roce_pkg::net_beat_t  net_tx,
  output logic                 net_tx_valid,
  input  logic                 net_tx_ready
);

  typedef enum logic {
    PASS,
    CRC
  } icrc_state_e;

  icrc_state_e                   state;
  logic [roce_pkg::NET_BITS-1:0] crc_q;
  logic                          in_fire;
  logic                          crc_fire;

  // fold one beat into the running crc
  // bytes from lsb up, each byte lsb first, so plain bit order 0..31
  function automatic logic [roce_pkg::NET_BITS-1:0] crc_step(
    input logic [roce_pkg::NET_BITS-1:0] crc_in,
    input logic [roce_pkg::NET_BITS-1:0] data
  );
    logic [roce_pkg::NET_BITS-1:0] c;
    logic                          fb;
    c = crc_in;
    for (int i = 0; i < roce_pkg::NET_BITS; i++) begin
      fb = c[0] ^ data[i];
      c  = c >> 1;
      if (fb) begin
        c = c ^ roce_pkg::CRC_POLY;
      end
    end
    return c;
  endfunction

  // output mux
  always_comb begin
    if (state == PASS) begin
      // straight through, end of packet is moved to the crc beat
      stack_tx_ready = net_tx_ready;
      net_tx_valid   = stack_tx_valid;
      net_tx.data    = stack_tx.data;
      net_tx.last    = 1'b0;
    end else begin
      // core held off while the crc goes out
      stack_tx_ready = 1'b0;
      net_tx_valid   = 1'b1;
      net_tx.data    = ~crc_q;
      net_tx.last    = 1'b1;
    end
  end

  assign in_fire  = (state == PASS) & stack_tx_valid & net_tx_ready;
  assign crc_fire = (state == CRC) & net_tx_ready;

  // state and running crc
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= PASS;
      crc_q <= roce_pkg::CRC_INIT;
    end else begin
      if (in_fire) begin
        crc_q <= crc_step(crc_q, stack_tx.data);
        if (stack_tx.last) begin
          state <= CRC;
        end
      end
      if (crc_fire) begin
        // fresh start for the next packet
        crc_q <= roce_pkg::CRC_INIT;
        state <= PASS;
      end
    end
  end

endmodule

// ==== source/stack_stats.sv ====
/*
 * Stack status counters
 * counts packets sent to the network and acks delivered to the user,
 * each new value shown with a one-cycle valid pulse
 */
module stack_stats (
  input  logic                            nclk,
  input  logic                            arst_n,

  // observed events
  input  logic                            net_tx_last,
  input  logic                            net_tx_fire,
  input  logic                            ack_fire,

  // counter outputs
  output logic [roce_pkg::COUNT_BITS-1:0] tx_pkg_count_data,
  output logic                            tx_pkg_count_valid,
  output logic [roce_pkg::COUNT_BITS-1:0] ack_count_data,
  output logic                            ack_count_valid
);

  // slot 0 tx packets, slot 1 acks
  localparam int N_CNT = 2;

  logic [N_CNT-1:0]                event_hit;
  logic [roce_pkg::COUNT_BITS-1:0] count_q [N_CNT];
  logic [N_CNT-1:0]                valid_q;

  // a packet ends on the transfer of the crc beat
  assign event_hit[0] = net_tx_fire & net_tx_last;
  assign event_hit[1] = ack_fire;

  // counters and change pulses
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < N_CNT; i++) begin
        count_q[i] <= '0;
      end
      valid_q <= '0;
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (event_hit[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
      // pulse lines up with the new count
      valid_q <= event_hit;
    end
  end

  assign tx_pkg_count_data  = count_q[0];
  assign tx_pkg_count_valid = valid_q[0];
  assign ack_count_data     = count_q[1];
  assign ack_count_valid    = valid_q[1];

endmodule

// ==== source/roce_stack.sv ====
/*
 * RoCE stack glue
 * wraps the external protocol core with send-queue flow control,
 * ack unframing, outgoing ICRC insertion and status counters
 */
module roce_stack #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                                 nclk,
  input  logic                                 arst_n,

  // user send queue
  input  roce_pkg::rdma_req_t                  sq_req,
  input  logic                                 sq_valid,
  output logic                                 sq_ready,

  // core send queue
  output logic [roce_pkg::SQ_FRAME_BITS-1:0]   stack_sq_frame,
  output logic                                 stack_sq_valid,
  input  logic                                 stack_sq_ready,

  // core acks
  input  logic [roce_pkg::ACK_FRAME_BITS-1:0]  stack_ack_frame,
  input  logic                                 stack_ack_valid,
  output logic                                 stack_ack_ready,

  // user acks
  output roce_pkg::rdma_ack_t                  ack,
  output logic                                 ack_valid,
  input  logic                                 ack_ready,

  // core tx stream
  input  roce_pkg::net_beat_t                  stack_tx,
  input  logic                                 stack_tx_valid,
  output logic                                 stack_tx_ready,

  // network tx stream
  output roce_pkg::net_beat_t                  net_tx,
  output logic                                 net_tx_valid,
  input  logic                                 net_tx_ready,

  // status
  output logic [roce_pkg::COUNT_BITS-1:0]      tx_pkg_count_data,
  output logic                                 tx_pkg_count_valid,
  output logic [roce_pkg::COUNT_BITS-1:0]      ack_count_data,
  output logic                                 ack_count_valid
);

  logic net_tx_fire;
  logic ack_fire;

  // transfer strobes seen by the counters
  assign net_tx_fire = net_tx_valid & net_tx_ready;
  assign ack_fire    = ack_valid & ack_ready;

  // flow control and reframing
  rdma_flow #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) inst_rdma_flow (
    .nclk            (nclk),
    .arst_n          (arst_n),
    .sq_req          (sq_req),
    .sq_valid        (sq_valid),
    .sq_ready        (sq_ready),
    .stack_sq_frame  (stack_sq_frame),
    .stack_sq_valid  (stack_sq_valid),
    .stack_sq_ready  (stack_sq_ready),
    .stack_ack_frame (stack_ack_frame),
    .stack_ack_valid (stack_ack_valid),
    .stack_ack_ready (stack_ack_ready),
    .ack             (ack),
    .ack_valid       (ack_valid),
    .ack_ready       (ack_ready)
  );

  // crc on the outgoing datapath
  icrc inst_icrc (
    .nclk           (nclk),
    .arst_n         (arst_n),
    .stack_tx       (stack_tx),
    .stack_tx_valid (stack_tx_valid),
    .stack_tx_ready (stack_tx_ready),
    .net_tx         (net_tx),
    .net_tx_valid   (net_tx_valid),
    .net_tx_ready   (net_tx_ready)
  );

  stack_stats inst_stack_stats (
    .nclk               (nclk),
    .arst_n             (arst_n),
    .net_tx_last        (net_tx.last),
    .net_tx_fire        (net_tx_fire),
    .ack_fire           (ack_fire),
    .tx_pkg_count_data  (tx_pkg_count_data),
    .tx_pkg_count_valid (tx_pkg_count_valid),
    .ack_count_data     (ack_count_data),
    .ack_count_valid    (ack_count_valid)
  );

endmodule

// ==== test/roce_stack_assert.sv ====
/*
 * RoCE stack assertions
 * credit limits in the flow block and output stability of the
 * ICRC stage under network back-pressure
 */
module roce_stack_assert #(
  parameter int MAX_OUTSTANDING = 4,
  parameter int CNT_W           = 8
) (
  input logic                nclk,
  input logic                arst_n,
  input logic                sq_fire,
  input logic                ack_fire,
  input logic [CNT_W-1:0]    outstanding,
  input roce_pkg::net_beat_t net_tx,
  input logic                net_tx_valid,
  input logic                net_tx_ready
);

  int fail_count = 0;

  // count never passes the limit after a request
  sq_at_limit: assert property (@(posedge nclk) disable iff (!arst_n)
    sq_fire |=> outstanding <= MAX_OUTSTANDING)
    else begin
      fail_count++;
      $error("%0d requests in flight after a request", outstanding);
    end

  // ack only for a request in flight
  ack_at_zero: assert property (@(posedge nclk) disable iff (!arst_n)
    ack_fire |-> outstanding != 0)
    else begin
      fail_count++;
      $error("ack delivered with no request in flight");
    end

  // stalled beat must not move
  net_hold: assert property (@(posedge nclk) disable iff (!arst_n)
    net_tx_valid && !net_tx_ready |=> net_tx_valid && $stable(net_tx))
    else begin
      fail_count++;
      $error("net_tx changed while stalled");
    end

endmodule

// network side tied off here
bind rdma_flow roce_stack_assert #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING),
  .CNT_W           (CNT_BITS)
) i_flow_assert (
  .nclk         (nclk),
  .arst_n       (arst_n),
  .sq_fire      (sq_fire),
  .ack_fire     (ack_fire),
  .outstanding  (outstanding),
  .net_tx       ('0),
  .net_tx_valid (1'b0),
  .net_tx_ready (1'b1)
);

// flow side tied off here
bind icrc roce_stack_assert i_net_assert (
  .nclk         (nclk),
  .arst_n       (arst_n),
  .sq_fire      (1'b0),
  .ack_fire     (1'b0),
  .outstanding  ('0),
  .net_tx       (net_tx),
  .net_tx_valid (net_tx_valid),
  .net_tx_ready (net_tx_ready)
);

// ==== test/tb_roce_stack.sv ====
/*
 * RoCE stack testbench
 * plays user, protocol core and network around the stack with random
 * traffic from a fixed seed and checks every transfer against a model
 */
module tb_roce_stack;

  localparam int MAX_OUTSTANDING = 4;
  localparam int N_REQ           = 40;
  localparam int N_PKT           = 30;
  // acks held back this long at the start
  localparam int HOLD_CYCLES     = 30;
  localparam int WATCHDOG_CYCLES = (N_REQ + N_PKT) * 40;

  logic                                 nclk;
  logic                                 arst_n;
  roce_pkg::rdma_req_t                  sq_req;
  logic                                 sq_valid;
  logic                                 sq_ready;
  logic [roce_pkg::SQ_FRAME_BITS-1:0]   stack_sq_frame;
  logic                                 stack_sq_valid;
  logic                                 stack_sq_ready;
  logic [roce_pkg::ACK_FRAME_BITS-1:0]  stack_ack_frame;
  logic                                 stack_ack_valid;
  logic                                 stack_ack_ready;
  roce_pkg::rdma_ack_t                  ack;
  logic                                 ack_valid;
  logic                                 ack_ready;
  roce_pkg::net_beat_t                  stack_tx;
  logic                                 stack_tx_valid;
  logic                                 stack_tx_ready;
  roce_pkg::net_beat_t                  net_tx;
  logic                                 net_tx_valid;
  logic                                 net_tx_ready;
  logic [roce_pkg::COUNT_BITS-1:0]      tx_pkg_count_data;
  logic                                 tx_pkg_count_valid;
  logic [roce_pkg::COUNT_BITS-1:0]      ack_count_data;
  logic                                 ack_count_valid;

  integer seed = 32'hd354;

  // reference model state
  logic [roce_pkg::SQ_FRAME_BITS-1:0] exp_frames [$];
  roce_pkg::net_beat_t                exp_net [$];
  logic [roce_pkg::NET_BITS-1:0]      tx_beats [$];
  roce_pkg::rdma_ack_t                exp_ack;
  roce_pkg::net_beat_t                exp_beat;
  roce_pkg::rdma_req_t                req;
  int   outstanding = 0;
  int   req_made    = 0;
  int   req_sent    = 0;
  int   acks_owed   = 0;
  int   acks_done   = 0;
  int   pkts_made   = 0;
  int   pkts_done   = 0;
  int   hold_cnt    = 0;
  int   pkt_len;
  int   assert_fails;
  logic ack_hold    = 1'b1;
  logic tx_event    = 1'b0;
  logic ack_event   = 1'b0;
  logic done        = 1'b0;
  logic credit;
  logic crc_due;
  logic sq_xfer;
  logic ack_xfer;
  logic tx_xfer;
  logic net_xfer;
  logic [31:0] rnd;
  logic [31:0] crc;

  roce_stack #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_roce_stack (
    .nclk (nclk), .arst_n (arst_n),
    .sq_req (sq_req), .sq_valid (sq_valid), .sq_ready (sq_ready),
    .stack_sq_frame (stack_sq_frame), .stack_sq_valid (stack_sq_valid),
    .stack_sq_ready (stack_sq_ready),
    .stack_ack_frame (stack_ack_frame), .stack_ack_valid (stack_ack_valid),
    .stack_ack_ready (stack_ack_ready),
    .ack (ack), .ack_valid (ack_valid), .ack_ready (ack_ready),
    .stack_tx (stack_tx), .stack_tx_valid (stack_tx_valid), .stack_tx_ready (stack_tx_ready),
    .net_tx (net_tx), .net_tx_valid (net_tx_valid), .net_tx_ready (net_tx_ready),
    .tx_pkg_count_data (tx_pkg_count_data), .tx_pkg_count_valid (tx_pkg_count_valid),
    .ack_count_data (ack_count_data), .ack_count_valid (ack_count_valid)
  );

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Test failed");
    $fatal(1);
  endtask

  // true with the given percentage
  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 100) < pct;
  endfunction

  // reflected crc-32, one byte lsb first
  function automatic logic [31:0] crc_add_byte(input logic [31:0] c_in, input logic [7:0] b);
    logic [31:0] c;
    c = c_in ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      c = c[0] ? ((c >> 1) ^ roce_pkg::CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  // opcode at bit 0, len on top
  function automatic logic [roce_pkg::SQ_FRAME_BITS-1:0] frame_req(input roce_pkg::rdma_req_t r);
    return {r.len, r.vaddr, r.last, r.host, r.qpn, r.opcode};
  endfunction

  initial begin
    nclk = 1'b0;
    forever #5 nclk = ~nclk;
  end

  always @(posedge nclk) begin
    if (arst_n && !done) begin
      sq_xfer  = sq_valid && sq_ready;
      ack_xfer = stack_ack_valid && ack_ready;
      tx_xfer  = stack_tx_valid && stack_tx_ready;
      net_xfer = net_tx_valid && net_tx_ready;
      credit   = (outstanding < MAX_OUTSTANDING);
      // crc beat owed when the next expected beat closes a packet
      crc_due  = (exp_net.size() > 0) && exp_net[0].last;

      if (i_roce_stack.inst_rdma_flow.i_flow_assert.fail_count
          + i_roce_stack.inst_icrc.i_net_assert.fail_count != 0) begin
        fail_run("bound assertions reported failures");
      end

      // handshakes against the credit model
      check("sq_ready", sq_ready, stack_sq_ready && credit);
      check("stack_sq_valid", stack_sq_valid, sq_valid && credit);
      check("ack_valid", ack_valid, stack_ack_valid);
      check("stack_ack_ready", stack_ack_ready, ack_ready);
      // core held off only while the crc beat is owed
      check("stack_tx_ready", stack_tx_ready, net_tx_ready && !crc_due);
      check("net_tx_valid", net_tx_valid, stack_tx_valid || crc_due);
      // counters show the count of the previous edge
      check("tx_pkg_count_valid", tx_pkg_count_valid, tx_event);
      check("tx_pkg_count_data", tx_pkg_count_data, pkts_done);
      check("ack_count_valid", ack_count_valid, ack_event);
      check("ack_count_data", ack_count_data, acks_done);

      if (sq_xfer) begin
        if (exp_frames.size() == 0) fail_run("send-queue transfer with no request queued");
        check("stack_sq_frame", stack_sq_frame, exp_frames.pop_front());
        outstanding++;
        req_sent++;
        acks_owed++;
      end
      if (ack_xfer) begin
        check("ack", ack, exp_ack);
        outstanding--;
        acks_done++;
      end
      if (net_xfer) begin
        if (exp_net.size() == 0) fail_run("network beat with no packet pending");
        exp_beat = exp_net.pop_front();
        check("net_tx.data", net_tx.data, exp_beat.data);
        check("net_tx.last", net_tx.last, exp_beat.last);
        if (net_tx.last) pkts_done++;
      end
      tx_event  = net_xfer && net_tx.last;
      ack_event = ack_xfer;

      // acks withheld until the credit limit has been seen
      if (ack_hold) begin
        hold_cnt++;
        if (hold_cnt == HOLD_CYCLES) begin
          check("requests sent with acks withheld", req_sent, MAX_OUTSTANDING);
          ack_hold = 1'b0;
        end
      end

      // user
      if (sq_xfer || !sq_valid) begin
        if (req_made < N_REQ && (ack_hold || chance(75))) begin
          rnd = $random(seed);
          case (rnd[1:0])
            2'd0:    req.opcode = roce_pkg::RC_RDMA_READ;
            2'd1:    req.opcode = roce_pkg::RC_RDMA_WRITE;
            default: req.opcode = roce_pkg::RC_SEND;
          endcase
          req.qpn   = rnd[11:2];
          req.host  = rnd[12];
          req.last  = rnd[13];
          req.len   = rnd[31:16];
          req.vaddr = $random(seed);
          sq_req   <= req;
          sq_valid <= 1'b1;
          exp_frames.push_back(frame_req(req));
          req_made++;
        end else begin
          sq_valid <= 1'b0;
        end
      end

      // core send queue and acks
      stack_sq_ready <= ack_hold ? 1'b1 : chance(50);
      if (ack_xfer || !stack_ack_valid) begin
        if (!ack_hold && acks_owed > 0 && chance(60)) begin
          rnd = $random(seed);
          exp_ack.rd  = rnd[0];
          exp_ack.qpn = rnd[10:1];
          rnd = $random(seed);
          exp_ack.ssn = rnd[23:0];
          stack_ack_frame <= {exp_ack.ssn, exp_ack.qpn, exp_ack.rd};
          stack_ack_valid <= 1'b1;
          acks_owed--;
        end else begin
          stack_ack_valid <= 1'b0;
        end
      end
      ack_ready <= chance(70);

      // core tx packets, 1 to 6 beats, crc of all bytes appended
      if (tx_xfer) void'(tx_beats.pop_front());
      if (tx_xfer || !stack_tx_valid) begin
        if (tx_beats.size() == 0 && pkts_made < N_PKT && chance(50)) begin
          rnd = $random(seed);
          pkt_len = 1 + int'(rnd % 6);
          crc = roce_pkg::CRC_INIT;
          for (int b = 0; b < pkt_len; b++) begin
            rnd = $random(seed);
            tx_beats.push_back(rnd);
            exp_beat.data = rnd;
            exp_beat.last = 1'b0;
            exp_net.push_back(exp_beat);
            for (int k = 0; k < 4; k++) begin
              crc = crc_add_byte(crc, rnd[8*k +: 8]);
            end
          end
          exp_beat.data = ~crc;
          exp_beat.last = 1'b1;
          exp_net.push_back(exp_beat);
          pkts_made++;
        end
        if (tx_beats.size() > 0) begin
          stack_tx.data  <= tx_beats[0];
          stack_tx.last  <= (tx_beats.size() == 1);
          stack_tx_valid <= 1'b1;
        end else begin
          stack_tx_valid <= 1'b0;
        end
      end
      net_tx_ready <= chance(60);

      if (req_sent == N_REQ && acks_done == N_REQ && pkts_done == N_PKT && exp_net.size() == 0) begin
        done = 1'b1;
      end
    end
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge nclk);
    $display("watchdog expired, traffic not finished after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    arst_n          <= 1'b0;
    sq_req          <= '0;
    sq_valid        <= 1'b0;
    stack_sq_ready  <= 1'b0;
    stack_ack_frame <= '0;
    stack_ack_valid <= 1'b0;
    ack_ready       <= 1'b0;
    stack_tx        <= '0;
    stack_tx_valid  <= 1'b0;
    net_tx_ready    <= 1'b0;
    repeat (4) @(posedge nclk);
    arst_n <= 1'b1;
    wait (done);
    repeat (2) @(posedge nclk);
    check("final tx_pkg_count_data", tx_pkg_count_data, N_PKT);
    check("final ack_count_data", ack_count_data, N_REQ);
    assert_fails = i_roce_stack.inst_rdma_flow.i_flow_assert.fail_count
                 + i_roce_stack.inst_icrc.i_net_assert.fail_count;
    if (assert_fails != 0) begin
      fail_run("bound assertions reported failures");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
source/roce_pkg.sv
source/rdma_flow.sv
source/icrc.sv
source/stack_stats.sv
source/roce_stack.sv
test/roce_stack_assert.sv
test/tb_roce_stack.sv

// ==== Bender.yml ====
package:
  name: roce_stack

sources:
  - source/roce_pkg.sv
  - source/rdma_flow.sv
  - source/icrc.sv
  - source/stack_stats.sv
  - source/roce_stack.sv
  - target: test
    files:
      - test/roce_stack_assert.sv
      - test/tb_roce_stack.sv
